//--- include/lsu_params.svh
// width and depth macros for the load/store path, included by lsu_pkg and data_sram
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// data word and byte address width
`define LSU_WORD_WD 64

// register file index width
`define LSU_GPR_ADDR_WD 5

// data sram depth in 64-bit words, as log2 (2 KiB)
`define LSU_SRAM_AW 8

`endif

//--- logic/lsu_pkg.sv
// shared types of the load/store path; modules take them by wildcard import
`default_nettype none

package lsu_pkg;

  `include "lsu_params.svh"

  typedef logic [`LSU_WORD_WD-1:0]     word_t;      // data word or byte address
  typedef logic [`LSU_GPR_ADDR_WD-1:0] gpr_addr_t;
  typedef logic [2:0]                  mem_op_t;    // funct3 style: [2] unsigned, [1:0] size
  typedef logic [`LSU_WORD_WD/8-1:0]   strb_t;      // one bit per byte lane

  // op handed over by execute
  typedef struct packed {
    logic      gpr_wen;
    gpr_addr_t rd;
    logic      mem_ren;
    logic      mem_wen;
    mem_op_t   mem_op;
    word_t     alu_result;  // result, or address for loads and stores
    word_t     store_data;
  } ex_to_ms_t;

  typedef struct packed {
    logic      gpr_wen;
    gpr_addr_t rd;
    word_t     result;
  } ms_to_ws_t;

  // forwarded to decode
  typedef struct packed {
    gpr_addr_t rd;
    word_t     value;
  } bypass_t;

  typedef struct packed {
    logic  wen;
    word_t addr;
    strb_t wstrb;
    word_t wdata;
  } sram_req_t;

endpackage

`default_nettype wire

//--- logic/lsu_store.sv
// store formatter: byte strobe and lane-replicated write data for one store access
`timescale 1ns/1ps
`default_nettype none

module lsu_store
  import lsu_pkg::*;
(
  input  wire logic [2:0] i_addr_low,    // byte offset within the word
  input  wire mem_op_t    i_mem_op,
  input  wire word_t      i_store_data,
  output strb_t           o_wstrb,
  output word_t           o_wdata
);

  // data is copied into every lane, the strobe picks the one that counts
  always_comb begin
    unique case (i_mem_op[1:0])
      2'd0: begin  // sb
        o_wdata = {8{i_store_data[7:0]}};
        o_wstrb = strb_t'(8'b0000_0001 << i_addr_low);
      end
      2'd1: begin  // sh
        o_wdata = {4{i_store_data[15:0]}};
        o_wstrb = strb_t'(8'b0000_0011 << i_addr_low);
      end
      2'd2: begin  // sw
        o_wdata = {2{i_store_data[31:0]}};
        o_wstrb = strb_t'(8'b0000_1111 << i_addr_low);
      end
      default: begin  // sd, whole word
        o_wdata = i_store_data;
        o_wstrb = 8'hff;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- logic/lsu_load.sv
// load aligner: picks the addressed bytes from an sram word and extends them to 64 bits
`timescale 1ns/1ps
`default_nettype none

module lsu_load
  import lsu_pkg::*;
(
  input  wire logic [2:0] i_addr_low,
  input  wire word_t      i_rdata,
  input  wire mem_op_t    i_mem_op,
  output word_t           o_rdata
);

  word_t shifted;
  logic  sext;

  assign sext = ~i_mem_op[2];  // lbu, lhu, lwu clear it

  // addressed byte moved down to lane 0
  assign shifted = i_rdata >> {i_addr_low, 3'b000};

  always_comb begin
    unique case (i_mem_op[1:0])
      2'd0: begin
        o_rdata = {{56{sext & shifted[7]}}, shifted[7:0]};
      end
      2'd1: begin
        o_rdata = {{48{sext & shifted[15]}}, shifted[15:0]};
      end
      2'd2: begin
        o_rdata = {{32{sext & shifted[31]}}, shifted[31:0]};
      end
      default: begin
        o_rdata = shifted;  // ld, nothing to extend
      end
    endcase
  end

endmodule

`default_nettype wire

//--- logic/mem_req_stage.sv
// request stage between execute and memory stage, issues the sram access as its op moves on
`timescale 1ns/1ps
`default_nettype none

module mem_req_stage
  import lsu_pkg::*;
(
  input  wire logic      i_clk,
  input  wire logic      i_reset,
  // from execute
  input  wire logic      i_ex_valid,
  input  wire ex_to_ms_t i_ex_op,
  output logic           o_ex_allowin,
  // to memory stage
  input  wire logic      i_ms_allowin,
  output logic           o_rs_valid,
  output ex_to_ms_t      o_rs_bus,
  // to data sram
  output logic           o_sram_req,
  output sram_req_t      o_sram_bus
);

  logic      rs_valid;
  ex_to_ms_t rs_bus;
  logic      rs_is_mem;
  strb_t     st_wstrb;
  word_t     st_wdata;

  // always ready to go, so only the next stage can stall us
  assign o_ex_allowin = !rs_valid || i_ms_allowin;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      rs_valid <= 1'b0;
    end else if (o_ex_allowin) begin
      rs_valid <= i_ex_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ex_valid && o_ex_allowin) begin
      rs_bus <= i_ex_op;
    end
  end

  assign o_rs_valid = rs_valid;
  assign o_rs_bus   = rs_bus;

  assign rs_is_mem = rs_bus.mem_ren || rs_bus.mem_wen;

  // req fires with the forward transfer, data_ok then meets the op in mem_stage
  assign o_sram_req = rs_valid && i_ms_allowin && rs_is_mem;

  lsu_store u_lsu_store (
    .i_addr_low   (rs_bus.alu_result[2:0]),
    .i_mem_op     (rs_bus.mem_op),
    .i_store_data (rs_bus.store_data),
    .o_wstrb      (st_wstrb),
    .o_wdata      (st_wdata)
  );

  always_comb begin
    o_sram_bus.wen   = rs_bus.mem_wen;
    o_sram_bus.addr  = rs_bus.alu_result;
    o_sram_bus.wstrb = rs_bus.mem_wen ? st_wstrb : '0;  // loads write nothing
    o_sram_bus.wdata = st_wdata;
  end

endmodule

`default_nettype wire

//--- logic/mem_stage.sv
// memory stage: waits for sram data_ok, formats load data, drives write-back and bypass buses
`timescale 1ns/1ps
`default_nettype none

module mem_stage
  import lsu_pkg::*;
(
  input  wire logic      i_clk,
  input  wire logic      i_reset,
  // from request stage
  input  wire logic      i_rs_valid,
  input  wire ex_to_ms_t i_rs_bus,
  output logic           o_ms_allowin,
  // from data sram
  input  wire logic      i_data_ok,
  input  wire word_t     i_rdata,
  // to write-back
  input  wire logic      i_ws_allowin,
  output logic           o_ws_valid,
  output ms_to_ws_t      o_ws_bus,
  // to decode
  output bypass_t        o_bypass
);

  logic      ms_valid;
  ex_to_ms_t ms_bus;
  logic      ms_is_mem;
  logic      ms_ready_go;
  logic      data_held;    // answer came in while write-back was stalled
  word_t     rdata_hold;
  word_t     rdata_sel;
  word_t     load_data;
  word_t     final_result;

  assign ms_is_mem   = ms_bus.mem_ren || ms_bus.mem_wen;
  assign ms_ready_go = !ms_is_mem || i_data_ok || data_held;

  assign o_ms_allowin = !ms_valid || (ms_ready_go && i_ws_allowin);
  assign o_ws_valid   = ms_valid && ms_ready_go;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ms_valid <= 1'b0;
    end else if (o_ms_allowin) begin
      ms_valid <= i_rs_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rs_valid && o_ms_allowin) begin
      ms_bus <= i_rs_bus;
    end
  end

  // data_ok is a one-cycle pulse, keep it until the op leaves
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      data_held <= 1'b0;
    end else if (o_ms_allowin) begin
      data_held <= 1'b0;
    end else if (i_data_ok) begin
      data_held <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_data_ok) begin
      rdata_hold <= i_rdata;
    end
  end

  assign rdata_sel = data_held ? rdata_hold : i_rdata;

  lsu_load u_lsu_load (
    .i_addr_low (ms_bus.alu_result[2:0]),
    .i_rdata    (rdata_sel),
    .i_mem_op   (ms_bus.mem_op),
    .o_rdata    (load_data)
  );

  assign final_result = ms_bus.mem_ren ? load_data : ms_bus.alu_result;

  always_comb begin
    o_ws_bus.gpr_wen = ms_bus.gpr_wen;
    o_ws_bus.rd      = ms_bus.rd;
    o_ws_bus.result  = final_result;
  end

  // zero when empty or no register write
  always_comb begin
    o_bypass.rd    = (ms_valid && ms_bus.gpr_wen) ? ms_bus.rd : '0;
    o_bypass.value = (ms_valid && ms_bus.gpr_wen) ? final_result : '0;
  end

endmodule

`default_nettype wire

//--- logic/data_sram.sv
// byte-writable data sram model, answers each request with data_ok one cycle later
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module data_sram
  import lsu_pkg::*;
#(
  parameter int DEPTH_LOG2 = `LSU_SRAM_AW
) (
  input  wire logic      i_clk,
  input  wire logic      i_reset,
  input  wire logic      i_req,
  input  wire sram_req_t i_req_bus,
  output logic           o_data_ok,
  output word_t          o_rdata
);

  word_t                  mem [2**DEPTH_LOG2];
  logic  [DEPTH_LOG2-1:0] word_idx;

  assign word_idx = i_req_bus.addr[DEPTH_LOG2+2:3];  // drop the lane offset

  // power-up contents are zero
  initial begin
    for (int i = 0; i < 2**DEPTH_LOG2; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_req) begin
      if (i_req_bus.wen) begin
        for (int b = 0; b < `LSU_WORD_WD/8; b++) begin
          if (i_req_bus.wstrb[b]) begin
            mem[word_idx][b*8 +: 8] <= i_req_bus.wdata[b*8 +: 8];
          end
        end
      end
      o_rdata <= mem[word_idx];  // old word on a store, unused
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_data_ok <= 1'b0;
    end else begin
      o_data_ok <= i_req;
    end
  end

endmodule

`default_nettype wire

//--- logic/lsu_top.sv
// load/store top: request stage, memory stage and data sram between execute and write-back
`timescale 1ns/1ps
`default_nettype none

module lsu_top
  import lsu_pkg::*;
(
  input  wire logic      i_clk,
  input  wire logic      i_reset,
  // execute side
  input  wire logic      i_ex_valid,
  input  wire ex_to_ms_t i_ex_op,
  output logic           o_ex_allowin,
  // write-back side
  input  wire logic      i_ws_allowin,
  output logic           o_ws_valid,
  output ms_to_ws_t      o_ws_bus,
  output bypass_t        o_bypass
);

  logic      rs_valid;
  ex_to_ms_t rs_bus;
  logic      ms_allowin;
  logic      sram_req;
  sram_req_t sram_bus;
  logic      sram_data_ok;
  word_t     sram_rdata;

  mem_req_stage u_mem_req_stage (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_ex_valid   (i_ex_valid),
    .i_ex_op      (i_ex_op),
    .o_ex_allowin (o_ex_allowin),
    .i_ms_allowin (ms_allowin),
    .o_rs_valid   (rs_valid),
    .o_rs_bus     (rs_bus),
    .o_sram_req   (sram_req),
    .o_sram_bus   (sram_bus)
  );

  mem_stage u_mem_stage (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_rs_valid   (rs_valid),
    .i_rs_bus     (rs_bus),
    .o_ms_allowin (ms_allowin),
    .i_data_ok    (sram_data_ok),
    .i_rdata      (sram_rdata),
    .i_ws_allowin (i_ws_allowin),
    .o_ws_valid   (o_ws_valid),
    .o_ws_bus     (o_ws_bus),
    .o_bypass     (o_bypass)
  );

  data_sram u_data_sram (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_req     (sram_req),
    .i_req_bus (sram_bus),
    .o_data_ok (sram_data_ok),
    .o_rdata   (sram_rdata)
  );

endmodule

`default_nettype wire

//--- tb/lsu_asserts.sv
// handshake and reset assertions, bound into lsu_top
`timescale 1ns/1ps
`default_nettype none

module lsu_asserts (
  input wire logic i_clk,
  input wire logic i_reset,
  input wire logic i_sram_req,
  input wire logic i_data_ok,
  input wire logic i_ws_valid
);

  // the requesting op sits in mem_stage with its answer one cycle later
  req_with_transfer: assert property (@(posedge i_clk) disable iff (i_reset)
    i_sram_req |=> i_ws_valid)
    else $error("sram req without the op moving into mem_stage");

  data_ok_after_req: assert property (@(posedge i_clk) disable iff (i_reset)
    i_sram_req |=> i_data_ok)
    else $error("data_ok missing one cycle after req");

  data_ok_only_after_req: assert property (@(posedge i_clk) disable iff (i_reset)
    i_data_ok |-> $past(i_sram_req))
    else $error("data_ok without a req in the cycle before");

  ws_idle_after_reset: assert property (@(posedge i_clk) i_reset |=> !i_ws_valid)
    else $error("o_ws_valid high right after reset");

endmodule

bind lsu_top lsu_asserts u_lsu_asserts (
  .i_clk        (i_clk),
  .i_reset      (i_reset),
  .i_sram_req   (sram_req),
  .i_data_ok    (sram_data_ok),
  .i_ws_valid   (o_ws_valid)
);

`default_nettype wire

//--- tb/lsu_checker.sv
// testbench checker: models memory, queues expected write-back records and compares each transfer
`timescale 1ns/1ps
`default_nettype none

module lsu_checker
  import lsu_pkg::*;
(
  input  wire logic            i_clk,
  input  wire logic            i_reset,
  input  wire logic            i_ex_valid,
  input  wire ex_to_ms_t       i_ex_op,
  input  wire logic            i_ex_allowin,
  input  wire logic            i_ws_allowin,
  input  wire logic            i_ws_valid,
  input  wire ms_to_ws_t       i_ws_bus,
  input  wire bypass_t         i_bypass,
  input  wire logic [8*16-1:0] i_test_name,
  input  wire logic            i_check_latency,  // allowin held high, fixed latency
  output int                   o_pending,
  output int                   o_checks,
  output int                   o_errors
);

  logic [7:0] model_mem [2048] = '{default: 8'h00};
  ms_to_ws_t  exp_q [$];
  int         in_cycle_q [$];
  int         cycle = 0;
  int         checks = 0;
  int         errors = 0;

  assign o_pending = exp_q.size();
  assign o_checks  = checks;
  assign o_errors  = errors;

  // expected record from the access size, extension rule and model bytes
  function automatic ms_to_ws_t expect_record(input ex_to_ms_t op);
    ms_to_ws_t rec;
    word_t     v;
    int        nbytes;
    int        base;
    nbytes = 1 << op.mem_op[1:0];
    base = int'(op.alu_result[10:0]);
    rec.gpr_wen = op.gpr_wen;
    rec.rd = op.rd;
    rec.result = op.alu_result;
    if (op.mem_ren) begin
      v = '0;
      for (int i = 0; i < nbytes; i++) v[i*8 +: 8] = model_mem[base+i];
      if (!op.mem_op[2] && nbytes < 8 && v[nbytes*8-1]) begin
        for (int i = nbytes * 8; i < 64; i++) v[i] = 1'b1;  // sign fill
      end
      rec.result = v;
    end
    return rec;
  endfunction

  task automatic apply_store(input ex_to_ms_t op);
    int nbytes;
    int base;
    nbytes = 1 << op.mem_op[1:0];
    base = int'(op.alu_result[10:0]);
    for (int i = 0; i < nbytes; i++) model_mem[base+i] = op.store_data[i*8 +: 8];
  endtask

  always @(posedge i_clk) begin
    ms_to_ws_t exp_rec;
    bypass_t   exp_bp;
    int        lat;
    cycle++;
    if (!i_reset && i_ws_valid) begin
      if (exp_q.size() == 0) begin
        $display("unexpected write-back record in %0s, no op was outstanding", i_test_name);
        errors++;
      end else begin
        exp_rec      = exp_q[0];  // head stays queued while write-back stalls
        exp_bp.rd    = exp_rec.gpr_wen ? exp_rec.rd : '0;
        exp_bp.value = exp_rec.gpr_wen ? exp_rec.result : '0;
        if (i_bypass !== exp_bp) begin
          $display("error %0s: bypass expected %h actual %h", i_test_name, exp_bp, i_bypass);
          errors++;
        end
        if (i_ws_allowin) begin
          exp_rec = exp_q.pop_front();
          lat = cycle - in_cycle_q.pop_front();
          checks++;
          if (i_ws_bus !== exp_rec) begin
            $display("error %0s: expected wen=%0d rd=%0d result=%h actual wen=%0d rd=%0d result=%h",
                     i_test_name, exp_rec.gpr_wen, exp_rec.rd, exp_rec.result,
                     i_ws_bus.gpr_wen, i_ws_bus.rd, i_ws_bus.result);
            errors++;
          end
          if (i_check_latency && lat != 2) begin
            $display("error %0s: latency expected 2 actual %0d", i_test_name, lat);
            errors++;
          end
        end
      end
    end
    if (!i_reset && i_ex_valid && i_ex_allowin) begin
      exp_q.push_back(expect_record(i_ex_op));  // load sees every earlier store
      in_cycle_q.push_back(cycle);
      if (i_ex_op.mem_wen) apply_store(i_ex_op);
    end
  end

endmodule

`default_nettype wire

//--- tb/lsu_tb.sv
// testbench top for lsu_top: clock, reset, random op stimulus, back-pressure and run verdict
`timescale 1ns/1ps
`default_nettype none

module lsu_tb
  import lsu_pkg::*;
();

  localparam int N_NON_MEM  = 64;
  localparam int N_MEM      = 128;
  localparam int N_BP       = 192;
  // worst case about 8 cycles per op under back-pressure, plus margin
  localparam int MAX_CYCLES = (N_NON_MEM + N_MEM + N_BP) * 8 + 928;

  logic             clk;
  logic             reset;
  logic             ex_valid;
  ex_to_ms_t        ex_op;
  logic             ex_allowin;
  logic             ws_allowin = 1'b1;
  logic             ws_valid;
  ms_to_ws_t        ws_bus;
  bypass_t          bypass;
  logic             bp_on;
  logic             lat_check;
  logic [8*16-1:0]  test_name;
  integer           seed;
  int               cycles = 0;
  int               pending;
  int               checks;
  int               errors;
  int               tb_errors;

  lsu_top UUT (
    .i_clk (clk), .i_reset (reset),
    .i_ex_valid (ex_valid), .i_ex_op (ex_op), .o_ex_allowin (ex_allowin),
    .i_ws_allowin (ws_allowin), .o_ws_valid (ws_valid), .o_ws_bus (ws_bus),
    .o_bypass (bypass)
  );

  lsu_checker u_checker (
    .i_clk (clk), .i_reset (reset),
    .i_ex_valid (ex_valid), .i_ex_op (ex_op), .i_ex_allowin (ex_allowin),
    .i_ws_allowin (ws_allowin), .i_ws_valid (ws_valid), .i_ws_bus (ws_bus),
    .i_bypass (bypass), .i_test_name (test_name), .i_check_latency (lat_check),
    .o_pending (pending), .o_checks (checks), .o_errors (errors)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    ws_allowin <= bp_on ? 1'($random(seed)) : 1'b1;  // about half the cycles stalled
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // kind 0 alu, 1 load, 2 store, 3 load or store, 4 any
  task automatic build_op(input int kind, input logic [10:0] addr_mask, output ex_to_ms_t op);
    logic [31:0] r;
    r = $random(seed);
    op = '0;
    op.rd = r[4:0];
    op.alu_result = {$random(seed), $random(seed)};
    op.store_data = {$random(seed), $random(seed)};
    if (kind == 4) kind = (r[6:5] == 2'd0) ? 0 : 3;
    if (kind == 3) kind = r[7] ? 1 : 2;
    case (kind)
      0: begin
        op.gpr_wen = r[8];
        op.mem_op  = r[11:9];
      end
      1: begin
        op.gpr_wen = 1'b1;
        op.mem_ren = 1'b1;
        op.mem_op  = 3'(r[15:12] % 7);  // lb .. lwu
      end
      default: begin
        op.mem_wen = 1'b1;
        op.mem_op  = {1'b0, r[10:9]};
      end
    endcase
    if (kind != 0) begin
      op.alu_result = {53'd0, op.alu_result[10:0] & addr_mask & ~((11'd1 << op.mem_op[1:0]) - 11'd1)};
    end
  endtask

  // called on a rising edge, returns on the edge of the transfer
  task automatic send_op(input ex_to_ms_t op);
    ex_valid <= 1'b1;
    ex_op    <= op;
    @(posedge clk);
    while (!ex_allowin) @(posedge clk);
    ex_valid <= 1'b0;
  endtask

  task automatic run_test(input logic [8*16-1:0] name, input int kind, input int count,
                          input logic [10:0] addr_mask, input logic backpressure);
    ex_to_ms_t   op;
    logic [31:0] r;
    int          checks_at;
    int          errors_at;
    test_name <= name;
    lat_check <= !backpressure;
    bp_on     <= backpressure;
    checks_at = checks;
    errors_at = errors;
    for (int i = 0; i < count; i++) begin
      build_op(kind, addr_mask, op);
      send_op(op);
      r = $random(seed);
      if (backpressure && r[1:0] == 2'd0) @(posedge clk);  // idle gap
    end
    bp_on <= 1'b0;
    do @(negedge clk); while (pending != 0);
    $display("test %0s: %0d checks, %0d errors", name, checks - checks_at, errors - errors_at);
    @(posedge clk);
  endtask

  initial begin
    seed      = 32'h0e65c68c;
    reset     = 1'b1;
    ex_valid  = 1'b0;
    ex_op     = '0;
    bp_on     = 1'b0;
    lat_check = 1'b0;
    test_name = "reset_state";
    tb_errors = 0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    if (ws_valid !== 1'b0 || ex_allowin !== 1'b1) begin
      $display("error reset_state: expected ws_valid=0 ex_allowin=1 actual ws_valid=%b ex_allowin=%b",
               ws_valid, ex_allowin);
      tb_errors++;
    end
    $display("test reset_state: 1 checks, %0d errors", tb_errors);
    @(posedge clk);
    run_test("non_mem", 0, N_NON_MEM, 11'h7ff, 1'b0);
    run_test("store_load", 3, N_MEM, 11'h03f, 1'b0);
    run_test("backpressure", 4, N_BP, 11'h63f, 1'b1);  // spread over low and high words
    $display("total: %0d checks, %0d errors", checks + 1, errors + tb_errors);
    if (errors + tb_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
logic/lsu_pkg.sv
logic/lsu_store.sv
logic/lsu_load.sv
logic/mem_req_stage.sv
logic/mem_stage.sv
logic/data_sram.sv
logic/lsu_top.sv
tb/lsu_asserts.sv
tb/lsu_checker.sv
tb/lsu_tb.sv

//--- run.sh
#!/bin/sh
# build the load/store testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module lsu_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vlsu_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation PASSED"; then
  exit 0
fi
exit 1
